//--- conv_engine.sv
`timescale 1ns/1ns
`default_nettype none
`include "npt_params.svh"

module conv_engine (
    input  wire logic                     i_clk,
    input  wire logic                     i_reset,
    input  wire logic                     i_start,    // Loaded pulse
    output npt_data_pkg::bram_addr_t      o_pix_addr,
    input  wire npt_data_pkg::pixel_t     i_pix_data,
    output npt_data_pkg::ker_addr_t       o_ker_addr,
    input  wire npt_data_pkg::weight_t    i_ker_data,
    output npt_data_pkg::acc_t            o_result,
    output logic                          o_result_valid,
    output logic                          o_done
);
    import npt_data_pkg::*;
    import npt_ctrl_pkg::*;

    localparam int POS_W    = $clog2(`NPT_IMG_DIM); // Covers row + kernel offset
    localparam int KOFF_W   = $clog2(`NPT_KER_DIM);
    localparam int LAST_POS = `NPT_OUT_DIM - 1;
    localparam int LAST_K   = `NPT_KER_DIM - 1;

    conv_state_e                         state;
    logic [POS_W-1:0]                    out_row;   // Output position
    logic [POS_W-1:0]                    out_col;
    logic [KOFF_W-1:0]                   k_row;     // Tap offset inside window
    logic [KOFF_W-1:0]                   k_col;
    ker_addr_t                           tap;       // Issued tap
    ker_addr_t                           tap_d;     // Tap whose pixel is arriving
    logic                                mac_valid; // Pixel on i_pix_data is live
    logic [POS_W-1:0]                    pix_row;
    logic [POS_W-1:0]                    pix_col;
    logic signed [2*`NPT_DATA_WIDTH-1:0] product;
    acc_t                                acc;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state   <= CV_IDLE;
            out_row <= '0;
            out_col <= '0;
            tap     <= '0;
            k_row   <= '0;
            k_col   <= '0;
        end else begin
            case (state)
                CV_IDLE: begin
                    if (i_start) begin
                        state   <= CV_TAP;
                        out_row <= '0;
                        out_col <= '0;
                    end
                end
                CV_TAP: begin
                    if (tap == ker_addr_t'(`NPT_KER_TAPS - 1)) begin
                        state <= CV_DRAIN;
                        tap   <= '0;       // Ready for next window
                        k_row <= '0;
                        k_col <= '0;
                    end else begin
                        tap <= tap + 1'b1;
                        if (k_col == KOFF_W'(LAST_K)) begin
                            k_col <= '0;
                            k_row <= k_row + 1'b1;
                        end else begin
                            k_col <= k_col + 1'b1;
                        end
                    end
                end
                CV_DRAIN: state <= CV_EMIT;
                CV_EMIT: begin
                    state <= CV_TAP;
                    if (out_col == POS_W'(LAST_POS)) begin
                        out_col <= '0;
                        if (out_row == POS_W'(LAST_POS)) begin
                            state <= CV_FINISH; // 36th output just left
                        end else begin
                            out_row <= out_row + 1'b1;
                        end
                    end else begin
                        out_col <= out_col + 1'b1;
                    end
                end
                CV_FINISH: state <= CV_IDLE;
                default:   state <= CV_IDLE;
            endcase
        end
    end

    // Memory latency stage where the kernel read address follows the pixel
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            mac_valid <= 1'b0;
            tap_d     <= '0;
        end else begin
            mac_valid <= (state == CV_TAP);
            tap_d     <= tap;
        end
    end

    assign pix_row    = out_row + POS_W'(k_row);
    assign pix_col    = out_col + POS_W'(k_col);
    assign o_pix_addr = bram_addr_t'(int'(pix_row) * `NPT_IMG_DIM + int'(pix_col));
    assign o_ker_addr = tap_d;
    assign product    = i_pix_data * i_ker_data; // Signed 8x8

    always_ff @(posedge i_clk) begin
        if ((state == CV_TAP) && (tap == '0)) begin
            acc <= '0; // New window with no pixel in flight yet
        end else if (mac_valid) begin
            acc <= acc + acc_t'(product); // Sign extended
        end
    end

    assign o_result       = acc;
    assign o_result_valid = (state == CV_EMIT);
    assign o_done         = (state == CV_FINISH);

    // Loader kicks the engine only when it sits idle
    a_start_when_idle : assert property (@(posedge i_clk) disable iff (i_reset)
        i_start |-> (state == CV_IDLE))
        else $error("loaded pulse while the engine is running");

endmodule

`default_nettype wire

//--- feature_bram.sv
`timescale 1ns/1ns
`default_nettype none
`include "npt_params.svh"

module feature_bram (
    input  wire logic                     i_clk,
    input  wire logic                     i_wr_en,     // External load port
    input  wire npt_data_pkg::bram_addr_t i_wr_addr,
    input  wire npt_data_pkg::pixel_t     i_wr_data,
    input  wire npt_data_pkg::bram_addr_t i_rd_addr_a, // Kernel loader side
    output npt_data_pkg::pixel_t          o_rd_data_a,
    input  wire npt_data_pkg::bram_addr_t i_rd_addr_b, // Convolution engine side
    output npt_data_pkg::pixel_t          o_rd_data_b
);
    import npt_data_pkg::*;

    localparam int DEPTH = 1 << `NPT_BRAM_ADDR_WIDTH; // 128 words

    // Image and kernel share one array
    pixel_t mem [DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // Both read ports registered with data one cycle after address
    always_ff @(posedge i_clk) begin
        o_rd_data_a <= mem[i_rd_addr_a]; // Weights
        o_rd_data_b <= mem[i_rd_addr_b]; // Pixels
    end

    // External writer must present a known address
    a_wr_addr_known : assert property (@(posedge i_clk)
        i_wr_en |-> !$isunknown(i_wr_addr))
        else $error("feature_bram write address unknown");

endmodule

`default_nettype wire

//--- kernel_loader.sv
`timescale 1ns/1ns
`default_nettype none
`include "npt_params.svh"

module kernel_loader (
    input  wire logic                     i_clk,
    input  wire logic                     i_reset,
    input  wire logic                     i_start,
    input  wire npt_data_pkg::bram_addr_t i_kernel_base, // Valid with i_start
    output npt_data_pkg::bram_addr_t      o_bram_addr,
    input  wire npt_data_pkg::weight_t    i_bram_data,
    output logic                          o_ker_wr_en,
    output npt_data_pkg::ker_addr_t       o_ker_wr_addr,
    output npt_data_pkg::weight_t         o_ker_wr_data,
    output logic                          o_loaded,      // Starts the engine
    input  wire logic                     i_conv_done,
    output logic                          o_busy
);
    import npt_data_pkg::*;
    import npt_ctrl_pkg::*;

    loader_state_e state;
    bram_addr_t    base_q;   // Kernel base latched on start
    ker_addr_t     tap;      // Weight currently moved
    logic          busy_q;   // Covers load and convolution
    logic          start_ok;

    // Start only from a quiet unit
    assign start_ok = i_start && (state == LD_IDLE) && !busy_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state  <= LD_IDLE;
            tap    <= '0;
            busy_q <= 1'b0;
        end else begin
            case (state)
                LD_IDLE: begin
                    if (start_ok) begin
                        state <= LD_READ;
                        tap   <= '0;
                    end
                end
                LD_READ:  state <= LD_WRITE; // Wait out memory latency
                LD_WRITE: begin
                    if (tap == ker_addr_t'(`NPT_KER_TAPS - 1)) begin
                        state <= LD_DONE;
                    end else begin
                        state <= LD_READ;
                        tap   <= tap + 1'b1;
                    end
                end
                LD_DONE:  state <= LD_IDLE;
                default:  state <= LD_IDLE;
            endcase
            if (start_ok) begin
                busy_q <= 1'b1;
            end else if (i_conv_done) begin
                busy_q <= 1'b0; // Low from the cycle after done
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (start_ok) begin
            base_q <= i_kernel_base;
        end
    end

    assign o_bram_addr   = base_q + bram_addr_t'(tap); // Row-major kernel words
    assign o_ker_wr_en   = (state == LD_WRITE);
    assign o_ker_wr_addr = tap;
    assign o_ker_wr_data = i_bram_data; // Registered read data lands here in WRITE
    assign o_loaded      = (state == LD_DONE);
    assign o_busy        = busy_q;

    // Engine cannot finish while the kernel is still moving
    a_no_done_in_load : assert property (@(posedge i_clk) disable iff (i_reset)
        (state != LD_IDLE) |-> !i_conv_done)
        else $error("convolution done pulse during kernel load");

endmodule

`default_nettype wire

//--- kernel_reg.sv
`timescale 1ns/1ns
`default_nettype none
`include "npt_params.svh"

module kernel_reg (
    input  wire logic                    i_clk,
    input  wire logic                    i_reset,
    input  wire logic                    i_wr_en,   // From loader
    input  wire npt_data_pkg::ker_addr_t i_wr_addr,
    input  wire npt_data_pkg::weight_t   i_wr_data,
    input  wire npt_data_pkg::ker_addr_t i_rd_addr, // From engine
    output npt_data_pkg::weight_t        o_rd_data
);
    import npt_data_pkg::*;

    localparam int TAPS = `NPT_KER_TAPS;

    weight_t regs [TAPS]; // Row-major 3x3 weights

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < TAPS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (int'(i_wr_addr) < TAPS)) begin
            regs[i_wr_addr] <= i_wr_data; // Visible next cycle
        end
    end

    // Combinational read, unused addresses read as zero
    assign o_rd_data = (int'(i_rd_addr) < TAPS) ? regs[i_rd_addr] : '0;

    // Loader and engine must both stay inside the nine taps
    a_addr_range : assert property (@(posedge i_clk) disable iff (i_reset)
        (int'(i_rd_addr) < TAPS) && (!i_wr_en || (int'(i_wr_addr) < TAPS)))
        else $error("kernel_reg address beyond tap 8");

endmodule

`default_nettype wire

//--- npt_ctrl_pkg.sv
`default_nettype none

package npt_ctrl_pkg;

    // Kernel loader sequence
    // One READ/WRITE pair per tap, so nine pairs for the whole kernel
    typedef enum logic [1:0] {
        LD_IDLE  = 2'd0, // Waiting for an accepted start
        LD_READ  = 2'd1, // Memory address on port A
        LD_WRITE = 2'd2, // Registered weight written to kernel file
        LD_DONE  = 2'd3  // One cycle loaded pulse
    } loader_state_e;

    // Convolution engine sequence, fixed 11 cycles per output
    typedef enum logic [2:0] {
        CV_IDLE   = 3'd0, // Waiting for loaded pulse
        CV_TAP    = 3'd1, // Nine tap addresses issued
        CV_DRAIN  = 3'd2, // Last pixel still in memory read stage
        CV_EMIT   = 3'd3, // Result strobed out
        CV_FINISH = 3'd4  // Done pulse after last output
    } conv_state_e;

endpackage

`default_nettype wire

//--- npt_data_pkg.sv
`default_nettype none
`include "npt_params.svh"

package npt_data_pkg;

    // Image sample, also the memory word
    typedef logic signed [`NPT_DATA_WIDTH-1:0] pixel_t;

    // Kernel weight, same width as a pixel
    typedef logic signed [`NPT_DATA_WIDTH-1:0] weight_t;

    // Full precision sum of nine products
    typedef logic signed [`NPT_ACC_WIDTH-1:0] acc_t;

    // Shared memory address
    typedef logic [`NPT_BRAM_ADDR_WIDTH-1:0] bram_addr_t;

    // Kernel register tap index
    typedef logic [`NPT_KER_ADDR_WIDTH-1:0] ker_addr_t;

endpackage

`default_nettype wire

//--- npt_params.svh
`ifndef NPT_PARAMS_SVH
`define NPT_PARAMS_SVH

// Frame and kernel geometry
`define NPT_IMG_DIM 8       // Square input image side
`define NPT_KER_DIM 3       // Square kernel side
`define NPT_OUT_DIM 6       // Valid-only output side, IMG - KER + 1
`define NPT_KER_TAPS 9      // KER_DIM squared

// Datapath widths
`define NPT_DATA_WIDTH 8    // Signed pixel and weight
// Nine 16-bit products need 4 guard bits, 20 bits covers the worst case
`define NPT_ACC_WIDTH 20

// Address widths
`define NPT_BRAM_ADDR_WIDTH 7   // 128 words, image at 0..63, kernel above
`define NPT_KER_ADDR_WIDTH 4    // Tap index 0..8

`endif

//--- npt_top.f
+incdir+.
npt_ctrl_pkg.sv
npt_data_pkg.sv
feature_bram.sv
kernel_loader.sv
kernel_reg.sv
conv_engine.sv
npt_top.sv
npt_top_tb.sv

//--- npt_top.sv
`timescale 1ns/1ns
`default_nettype none

module npt_top (
    input  wire logic                     i_clk,
    input  wire logic                     i_reset,
    input  wire logic                     i_start,
    input  wire npt_data_pkg::bram_addr_t i_kernel_base,
    input  wire logic                     i_wr_en,      // Image and kernel load
    input  wire npt_data_pkg::bram_addr_t i_wr_addr,
    input  wire npt_data_pkg::pixel_t     i_wr_data,
    output npt_data_pkg::acc_t            o_result,
    output logic                          o_result_valid,
    output logic                          o_done,
    output logic                          o_busy
);
    import npt_data_pkg::*;

    bram_addr_t ld_bram_addr;  // Loader read port A
    weight_t    ld_bram_data;
    logic       ker_wr_en;     // Loader to kernel file
    ker_addr_t  ker_wr_addr;
    weight_t    ker_wr_data;
    logic       loaded;        // Kicks the engine
    bram_addr_t pix_addr;      // Engine read port B
    pixel_t     pix_data;
    ker_addr_t  ker_rd_addr;
    weight_t    ker_rd_data;

    feature_bram u_bram (
        .i_clk       (i_clk),
        .i_wr_en     (i_wr_en),
        .i_wr_addr   (i_wr_addr),
        .i_wr_data   (i_wr_data),
        .i_rd_addr_a (ld_bram_addr),
        .o_rd_data_a (ld_bram_data),
        .i_rd_addr_b (pix_addr),
        .o_rd_data_b (pix_data)
    );

    kernel_loader u_loader (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_start       (i_start),
        .i_kernel_base (i_kernel_base),
        .o_bram_addr   (ld_bram_addr),
        .i_bram_data   (ld_bram_data),
        .o_ker_wr_en   (ker_wr_en),
        .o_ker_wr_addr (ker_wr_addr),
        .o_ker_wr_data (ker_wr_data),
        .o_loaded      (loaded),
        .i_conv_done   (o_done),     // Ends the busy window
        .o_busy        (o_busy)
    );

    kernel_reg u_kernel (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_wr_en   (ker_wr_en),
        .i_wr_addr (ker_wr_addr),
        .i_wr_data (ker_wr_data),
        .i_rd_addr (ker_rd_addr),
        .o_rd_data (ker_rd_data)
    );

    conv_engine u_conv (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_start        (loaded),
        .o_pix_addr     (pix_addr),
        .i_pix_data     (pix_data),
        .o_ker_addr     (ker_rd_addr),
        .i_ker_data     (ker_rd_data),
        .o_result       (o_result),
        .o_result_valid (o_result_valid),
        .o_done         (o_done)
    );

endmodule

`default_nettype wire

//--- npt_top_input.txt
// Per test: kernel base, 9 weights row-major, 8 image rows, 6 rows of expected sums
// Hex two's complement, pixels and weights 8 bit, sums 20 bit
40 // Test 1 kernel base
01 fe 03 fc 05 fa 07 f8 09
e0 e1 e2 e3 e4 e5 e6 e7
e8 e9 ea eb ec ed ee ef
f0 f1 f2 f3 f4 f5 f6 f7
f8 f9 fa fb fc fd fe ff
00 01 02 03 04 05 06 07
08 09 0a 0b 0c 0d 0e 0f
10 11 12 13 14 15 16 17
18 19 1a 1b 1c 1d 1e 1f
fffbf fffc4 fffc9 fffce fffd3 fffd8
fffe7 fffec ffff1 ffff6 ffffb 00000
0000f 00014 00019 0001e 00023 00028
00037 0003c 00041 00046 0004b 00050
0005f 00064 00069 0006e 00073 00078
00087 0008c 00091 00096 0009b 000a0
64 // Test 2 kernel base
ff fd fe fb ff fc fe fa fd
05 07 09 0b 0d 0f 11 13
02 04 06 08 0a 0c 0e 10
ff 01 03 05 07 09 0b 0d
fc fe 00 02 04 06 08 0a
f9 fb fd ff 01 03 05 07
f6 f8 fa fc fe 00 02 04
f3 f5 f7 f9 fb fd ff 01
f0 f2 f4 f6 f8 fa fc fe
fffa1 fff6b fff35 ffeff ffec9 ffe93
ffff2 fffbc fff86 fff50 fff1a ffee4
00043 0000d fffd7 fffa1 fff6b fff35
00094 0005e 00028 ffff2 fffbc fff86
000e5 000af 00079 00043 0000d fffd7
00136 00100 000ca 00094 0005e 00028

//--- npt_top_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "npt_params.svh"

module npt_top_tb;
    import npt_data_pkg::*;

    localparam int IMG_WORDS  = `NPT_IMG_DIM * `NPT_IMG_DIM;
    localparam int N_OUT      = `NPT_OUT_DIM * `NPT_OUT_DIM;
    localparam int TEST_WORDS = 1 + `NPT_KER_TAPS + IMG_WORDS + N_OUT; // 110 words per test
    localparam int EXP_OFS    = 1 + `NPT_KER_TAPS + IMG_WORDS;
    localparam int FIRST_AT   = 19 + 11;                    // Loader, then one output slot
    localparam int SLOT       = 11;                         // Cycles per output
    localparam int DONE_AT    = FIRST_AT + SLOT * (N_OUT - 1) + 1;
    localparam int RUN_LEN    = 420;                        // One full start-to-idle run
    localparam int LOAD_LEN   = 80;                         // 73 writes plus slack
    localparam int LIMIT      = 4 * RUN_LEN + 2 * LOAD_LEN + 160;

    logic       clk;
    logic       reset;
    logic       start;
    bram_addr_t kernel_base;
    logic       wr_en;
    bram_addr_t wr_addr;
    pixel_t     wr_data;
    acc_t       result;
    logic       result_valid;
    logic       done;
    logic       busy;

    logic [`NPT_ACC_WIDTH-1:0] vec [0:2*TEST_WORDS-1]; // Both tests, straight from the file
    int cycle_cnt = 0;
    int res_errs;     // Per run, set by run_conv
    int time_errs;
    int busy_errs;
    int rst_errs;
    int tests_failed;

    npt_top dut (
        .i_clk          (clk),
        .i_reset        (reset),
        .i_start        (start),
        .i_kernel_base  (kernel_base),
        .i_wr_en        (wr_en),
        .i_wr_addr      (wr_addr),
        .i_wr_data      (wr_data),
        .o_result       (result),
        .o_result_valid (result_valid),
        .o_done         (done),
        .o_busy         (busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // Watchdog over the whole run
    initial begin
        wait (cycle_cnt >= LIMIT);
        $display("Timeout: run stopped after %0d cycles", cycle_cnt);
        $display("Checks failed");
        $finish;
    end

    // Drive point, 1 ns after the rising edge
    task automatic drive_slot();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_gap();
        int n;
        n = 2 + int'($urandom % 8);
        repeat (n) drive_slot();
    endtask

    // Kernel words at the test's base, then the 64 pixels at 0..63
    task automatic load_memory(input int t);
        int base;
        base = t * TEST_WORDS;
        for (int k = 0; k < `NPT_KER_TAPS + IMG_WORDS; k++) begin
            drive_slot();
            wr_en   = 1'b1;
            wr_data = pixel_t'(vec[base + 1 + k]); // Weights then pixels, same file order
            if (k < `NPT_KER_TAPS) begin
                wr_addr = bram_addr_t'(int'(vec[base]) + k);
            end else begin
                wr_addr = bram_addr_t'(k - `NPT_KER_TAPS);
            end
        end
        drive_slot();
        wr_en = 1'b0;
    endtask

    // One start pulse, then watch every cycle until done; poke_at > 0 adds a second start
    task automatic run_conv(input int t, input int poke_at, input string res_name,
                            input string time_name, input string busy_name);
        int                        c0;
        int                        rel;
        int                        n;
        bit                        done_seen;
        logic [`NPT_ACC_WIDTH-1:0] exp_val;
        n         = 0;
        done_seen = 1'b0;
        res_errs  = 0;
        time_errs = 0;
        busy_errs = 0;
        drive_slot();
        start       = 1'b1;
        kernel_base = bram_addr_t'(vec[t * TEST_WORDS]);
        c0          = cycle_cnt;
        while (!done_seen && (cycle_cnt - c0 < RUN_LEN)) begin
            @(negedge clk);
            rel = cycle_cnt - c0;
            if (busy !== (rel >= 1)) begin // Busy from the cycle after start
                $display("FAILED %s expected %0b actual %0b at cycle %0d",
                         busy_name, rel >= 1, busy, rel);
                busy_errs++;
            end
            if (result_valid) begin
                if (rel != FIRST_AT + SLOT * n) begin
                    $display("FAILED %s expected cycle %0d actual cycle %0d",
                             time_name, FIRST_AT + SLOT * n, rel);
                    time_errs++;
                end
                if (n >= N_OUT) begin
                    $display("%s: extra result strobe %0d after the last output", time_name, n);
                    time_errs++;
                end else begin
                    exp_val = vec[t * TEST_WORDS + EXP_OFS + n]; // Raster order
                    if (result !== exp_val) begin
                        $display("FAILED %s output %0d expected %0d actual %0d",
                                 res_name, n, $signed(exp_val), result);
                        res_errs++;
                    end
                end
                n++;
            end
            if (done) begin
                if (rel != DONE_AT) begin
                    $display("FAILED %s expected done at cycle %0d actual cycle %0d",
                             time_name, DONE_AT, rel);
                    time_errs++;
                end
                done_seen = 1'b1;
            end
            drive_slot();
            start = (poke_at > 0) && (cycle_cnt - c0 == poke_at);
            if (start) begin
                kernel_base = '0; // Would load a wrong kernel if accepted
            end
        end
        if (!done_seen) begin
            $display("%s: no done pulse within %0d cycles of start", time_name, RUN_LEN);
            time_errs++;
        end
        if (n != N_OUT) begin
            $display("FAILED %s result count expected %0d actual %0d", time_name, N_OUT, n);
            time_errs++;
        end
        @(negedge clk);
        if (busy !== 1'b0) begin
            $display("FAILED %s expected 0 actual %0b after done", busy_name, busy);
            busy_errs++;
        end
        if (done !== 1'b0) begin
            $display("%s: done stayed high for more than one cycle", time_name);
            time_errs++;
        end
    endtask

    task automatic report(input string name, input int errs);
        if (errs == 0) begin
            $display("PASS %s", name);
        end else begin
            $display("FAIL %s with %0d errors", name, errs);
            tests_failed++;
        end
    endtask

    initial begin
        reset        = 1'b1;
        start        = 1'b0;
        kernel_base  = '0;
        wr_en        = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        tests_failed = 0;
        rst_errs     = 0;
        void'($urandom(32'h87e5a96d));
        $readmemh("npt_top_input.txt", vec);
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        // Mixed-sign kernel at 64, ignored restart 200 cycles in
        load_memory(0);
        idle_gap();
        run_conv(0, 200, "test1_results", "test2_strobe_timing", "test3_busy_level");
        report("test1_results", res_errs);
        report("test2_strobe_timing", time_errs);
        report("test3_busy_level", busy_errs);
        report("test4_start_while_busy", res_errs + time_errs);

        // All-negative kernel at 100, new image
        load_memory(1);
        idle_gap();
        run_conv(1, 0, "test5_base_100", "test5_base_100", "test5_base_100");
        report("test5_base_100", res_errs + time_errs + busy_errs);

        idle_gap();
        drive_slot();
        start       = 1'b1;
        kernel_base = bram_addr_t'(vec[TEST_WORDS]);
        drive_slot();
        start = 1'b0;
        repeat (100) drive_slot(); // Well inside the convolution
        reset = 1'b1;
        drive_slot();
        for (int k = 0; k < 20; k++) begin
            @(negedge clk);
            if (busy || result_valid || done) begin
                $display("test6_reset_mid_run: unit still active %0d cycles into reset", k);
                rst_errs++;
            end
            drive_slot();
            reset = (k < 2); // Three reset cycles, then quiet idle
        end
        run_conv(1, 0, "test6_reset_mid_run", "test6_reset_mid_run", "test6_reset_mid_run");
        report("test6_reset_mid_run", rst_errs + res_errs + time_errs + busy_errs);

        $display("Tests run 6, passing %0d, failing %0d", 6 - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module npt_top_tb \
    -f npt_top.f -o npt_sim \
    && ./obj_dir/npt_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "All checks passed" sim.log || { echo "No verdict in log"; exit 1; }
echo "Simulation PASSED"
